//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rate_loop
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_rate_loop.sv
`timescale 1ns/1ps

module tb_rate_loop
	import flight_types_pkg::*;
	import pid_cfg_pkg::*;
();

	localparam gains_t YAW_G = '{kp: 8'd20, ki: 8'd3, kd: 8'd10};
	localparam gains_t ROLL_G = '{kp: 8'd40, ki: 8'd12, kd: 8'd24};
	localparam gains_t PITCH_G = '{kp: 8'd48, ki: 8'd16, kd: 8'd30};
	localparam longint INTEG_MAX = 8388607;
	localparam int RANDOM_CYCLES = 200;
	localparam int SAT_HIGH_CYCLES = 260;
	localparam int SAT_LOW_CYCLES = 460;
	// single, cascade, busy and the rejected pulses
	localparam int FIXED_CYCLES = 8;
	localparam int TOTAL_CYCLES = FIXED_CYCLES + RANDOM_CYCLES + SAT_HIGH_CYCLES + SAT_LOW_CYCLES;
	localparam int TIMEOUT_NS = TOTAL_CYCLES * 20 * 100 + 20000;

	typedef struct {
		string name;
		int start_cyc;
		axis_rates_t axis;
		motor_cmd_t motor;
	} expect_t;

	logic start_signal;
	logic resetn;
	logic cycle_start;
	axis_rates_t rate_targets;
	axis_rates_t gyro_rates;
	tilt_errors_t angle_errors;
	throttle_t throttle;
	axis_rates_t axis_cmd;
	logic cmd_valid;
	motor_cmd_t motor_cmd;
	logic motor_valid;
	logic busy;

	expect_t cmd_q[$];
	expect_t motor_q[$];
	int cyc = 0;
	int pending;
	int error_count;
	// model memory indexed by axis as yaw then roll then pitch
	gains_t gains_m[3];
	longint integ_m[3];
	longint prev_m[3];

	rate_loop_top #(
		.YAW_GAINS   (YAW_G),
		.ROLL_GAINS  (ROLL_G),
		.PITCH_GAINS (PITCH_G)
	) dut (
		.start_signal (start_signal),
		.resetn       (resetn),
		.cycle_start  (cycle_start),
		.rate_targets (rate_targets),
		.gyro_rates   (gyro_rates),
		.angle_errors (angle_errors),
		.throttle     (throttle),
		.axis_cmd     (axis_cmd),
		.cmd_valid    (cmd_valid),
		.motor_cmd    (motor_cmd),
		.motor_valid  (motor_valid),
		.busy         (busy)
	);

	always #50 start_signal = ~start_signal;

	always @(posedge start_signal) cyc <= cyc + 1;

	function automatic longint clamp(input longint v, input longint lo, input longint hi);
		if (v > hi) return hi;
		if (v < lo) return lo;
		return v;
	endfunction

	// one PID step that also moves the integral and previous error on
	function automatic longint pid_reference(input int ax, input longint sp, input longint gyro);
		longint kp;
		longint ki;
		longint kd;
		longint err;
		longint integ_new;
		longint total;
		kp = longint'(gains_m[ax].kp);
		ki = longint'(gains_m[ax].ki);
		kd = longint'(gains_m[ax].kd);
		err = sp - ((gyro * 41) >>> 8);
		integ_new = clamp(integ_m[ax] + err, -INTEG_MAX, INTEG_MAX);
		total = (kp * err + kd * (err - prev_m[ax]) + ((ki * integ_new) >>> 8)) >>> 6;
		integ_m[ax] = integ_new;
		prev_m[ax] = err;
		return clamp(total, -32768, 32767);
	endfunction

	function automatic motor_word_t motor_reference(input longint sum);
		return motor_word_t'(clamp(sum, 0, 4095));
	endfunction

	function automatic expect_t reference_cycle(input axis_rates_t tgt, input axis_rates_t gy,
			input tilt_errors_t ang, input throttle_t thr);
		expect_t e;
		longint sp_roll;
		longint sp_pitch;
		longint y;
		longint r;
		longint p;
		longint t;
		sp_roll = clamp(longint'($signed(tgt.roll)) + longint'($signed(ang.roll)), -32768, 32767);
		sp_pitch = clamp(longint'($signed(tgt.pitch)) + longint'($signed(ang.pitch)), -32768, 32767);
		e.axis.yaw = rate_t'(pid_reference(0, longint'($signed(tgt.yaw)), longint'($signed(gy.yaw))));
		e.axis.roll = rate_t'(pid_reference(1, sp_roll, longint'($signed(gy.roll))));
		e.axis.pitch = rate_t'(pid_reference(2, sp_pitch, longint'($signed(gy.pitch))));
		// integer part of each 12.4 command
		y = longint'($signed(e.axis.yaw)) >>> 4;
		r = longint'($signed(e.axis.roll)) >>> 4;
		p = longint'($signed(e.axis.pitch)) >>> 4;
		t = longint'(thr);
		e.motor.front_left = motor_reference(t + p + r - y);
		e.motor.front_right = motor_reference(t + p - r + y);
		e.motor.rear_left = motor_reference(t - p + r + y);
		e.motor.rear_right = motor_reference(t - p - r - y);
		return e;
	endfunction

	task automatic stop_run(input string why);
		if (why.len() > 0) $display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (expected != actual) begin
			error_count++;
			$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
			stop_run("");
		end
	endtask

	function automatic rate_t random_rate(input int span);
		return rate_t'(int'($urandom % (2 * span + 1)) - span);
	endfunction

	function automatic axis_rates_t random_axes(input int span);
		axis_rates_t v;
		v.yaw = random_rate(span);
		v.roll = random_rate(span);
		v.pitch = random_rate(span);
		return v;
	endfunction

	// request is sampled at the second edge and busy is checked half a cycle later
	task automatic issue_cycle(input string name, input axis_rates_t tgt, input axis_rates_t gy,
			input tilt_errors_t ang, input throttle_t thr);
		expect_t e;
		@(posedge start_signal);
		rate_targets <= tgt;
		gyro_rates <= gy;
		angle_errors <= ang;
		throttle <= thr;
		cycle_start <= 1'b1;
		e = reference_cycle(tgt, gy, ang, thr);
		e.name = name;
		@(posedge start_signal);
		cycle_start <= 1'b0;
		e.start_cyc = cyc;
		cmd_q.push_back(e);
		pending++;
		@(negedge start_signal);
		check_value({name, " busy"}, 1, busy);
	endtask

	task automatic pulse_while_busy();
		@(posedge start_signal);
		rate_targets <= '{yaw: 16'sh5a5a, roll: -16'sd3000, pitch: 16'sd9000};
		gyro_rates <= '{yaw: -16'sd7000, roll: 16'sd6000, pitch: 16'sd100};
		throttle <= 12'd4000;
		cycle_start <= 1'b1;
		@(posedge start_signal);
		cycle_start <= 1'b0;
	endtask

	// extra cycles catch a stray cmd_valid
	task automatic wait_idle();
		while (pending != 0) @(posedge start_signal);
		repeat (8) @(posedge start_signal);
	endtask

	always @(negedge start_signal) begin : compare_outputs
		expect_t e;
		if (motor_valid) begin
			if (motor_q.size() == 0) begin
				stop_run("motor_valid was raised with no control cycle pending");
			end else begin
				e = motor_q.pop_front();
				check_value({e.name, " front_left"}, e.motor.front_left, motor_cmd.front_left);
				check_value({e.name, " front_right"}, e.motor.front_right, motor_cmd.front_right);
				check_value({e.name, " rear_left"}, e.motor.rear_left, motor_cmd.rear_left);
				check_value({e.name, " rear_right"}, e.motor.rear_right, motor_cmd.rear_right);
				check_value({e.name, " motor latency"}, 7, cyc - e.start_cyc);
				pending--;
			end
		end
		if (cmd_valid) begin
			if (cmd_q.size() == 0) begin
				stop_run("cmd_valid was raised with no control cycle pending");
			end else begin
				e = cmd_q.pop_front();
				check_value({e.name, " yaw"}, $signed(e.axis.yaw), $signed(axis_cmd.yaw));
				check_value({e.name, " roll"}, $signed(e.axis.roll), $signed(axis_cmd.roll));
				check_value({e.name, " pitch"}, $signed(e.axis.pitch), $signed(axis_cmd.pitch));
				check_value({e.name, " cmd latency"}, 6, cyc - e.start_cyc);
				check_value({e.name, " busy at cmd_valid"}, 0, busy);
				motor_q.push_back(e);
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		stop_run($sformatf("run timed out after %0d ns with %0d cycles pending", TIMEOUT_NS, pending));
	end

	initial begin : stimulus
		axis_rates_t tgt;
		axis_rates_t gy;
		tilt_errors_t ang;
		void'($urandom(32'h97dc));
		start_signal = 1'b0;
		resetn = 1'b0;
		cycle_start = 1'b0;
		rate_targets = '0;
		gyro_rates = '0;
		angle_errors = '0;
		throttle = '0;
		pending = 0;
		error_count = 0;
		gains_m[0] = YAW_G;
		gains_m[1] = ROLL_G;
		gains_m[2] = PITCH_G;
		for (int a = 0; a < 3; a++) begin
			integ_m[a] = 0;
			prev_m[a] = 0;
		end
		repeat (8) @(posedge start_signal);
		resetn <= 1'b1;

		// nothing moves before the first request
		repeat (4) begin
			@(negedge start_signal);
			check_value("reset busy", 0, busy);
			check_value("reset cmd_valid", 0, cmd_valid);
			check_value("reset motor_valid", 0, motor_valid);
			check_value("reset axis_cmd", 0, axis_cmd);
			check_value("reset motor_cmd", 0, motor_cmd);
		end

		tgt = '{yaw: 16'sd480, roll: -16'sd800, pitch: 16'sd1200};
		gy = '{yaw: 16'sd1500, roll: 16'sd2500, pitch: -16'sd4000};
		ang = '{roll: 16'sd0, pitch: 16'sd0};
		issue_cycle("single", tgt, gy, ang, 12'd1800);
		wait_idle();

		// next request lands on the cmd_valid edge
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			ang = '{roll: random_rate(1000), pitch: random_rate(1000)};
			issue_cycle("random", random_axes(4000), random_axes(20000), ang,
				throttle_t'($urandom % 4096));
			repeat (4) @(posedge start_signal);
		end
		wait_idle();

		// long run of full-scale error drives the integral into its upper limit
		tgt = '{yaw: 16'sh7fff, roll: 16'sh7fff, pitch: 16'sh7fff};
		gy = '{yaw: 16'sh8000, roll: 16'sh8000, pitch: 16'sh8000};
		ang = '{roll: 16'sh7fff, pitch: 16'sh7fff};
		for (int i = 0; i < SAT_HIGH_CYCLES; i++) begin
			issue_cycle("saturate high", tgt, gy, ang, (i % 2 == 0) ? 12'd4095 : 12'd0);
			repeat (4) @(posedge start_signal);
		end
		// the opposite error walks the integral down into its lower limit
		tgt = '{yaw: 16'sh8000, roll: 16'sh8000, pitch: 16'sh8000};
		gy = '{yaw: 16'sh7fff, roll: 16'sh7fff, pitch: 16'sh7fff};
		ang = '{roll: 16'sh8000, pitch: 16'sh8000};
		for (int i = 0; i < SAT_LOW_CYCLES; i++) begin
			issue_cycle("saturate low", tgt, gy, ang, (i % 2 == 0) ? 12'd0 : 12'd4095);
			repeat (4) @(posedge start_signal);
		end
		wait_idle();

		tgt = '{yaw: 16'sd320, roll: 16'sd160, pitch: -16'sd160};
		gy = '0;
		ang = '{roll: 16'sd640, pitch: -16'sd480};
		issue_cycle("cascade", tgt, gy, ang, 12'd2000);
		wait_idle();
		tgt.roll = 16'sh7000;
		tgt.pitch = -16'sh7000;
		ang = '{roll: 16'sh7000, pitch: -16'sh7000};
		issue_cycle("cascade saturated", tgt, gy, ang, 12'd2000);
		wait_idle();

		// pulses during busy must leave the loop memory alone
		ang = '{roll: 16'sd0, pitch: 16'sd0};
		issue_cycle("busy", tgt, gy, ang, 12'd1500);
		pulse_while_busy();
		pulse_while_busy();
		wait_idle();
		issue_cycle("after busy", tgt, gy, ang, 12'd1500);
		wait_idle();

		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
rtl/flight_types_pkg.sv
rtl/pid_cfg_pkg.sv
rtl/rate_pid.sv
rtl/body_frame_controller.sv
rtl/motor_mixer.sv
rtl/rate_loop_top.sv
bench/tb_rate_loop.sv

//--- rtl/body_frame_controller.sv
`timescale 1ns/1ps

module body_frame_controller
	import flight_types_pkg::*;
	import pid_cfg_pkg::*;
#(
	parameter gains_t YAW_GAINS = '{kp: 8'd16, ki: 8'd0, kd: 8'd0},
	parameter gains_t ROLL_GAINS = '{kp: 8'd16, ki: 8'd0, kd: 8'd0},
	parameter gains_t PITCH_GAINS = '{kp: 8'd16, ki: 8'd0, kd: 8'd0}
) (
	input  logic         start_signal,
	input  logic         resetn,
	input  logic         cycle_start,
	input  axis_rates_t  rate_targets,
	input  axis_rates_t  gyro_rates,
	input  tilt_errors_t angle_errors,
	input  throttle_t    throttle,
	output axis_rates_t  axis_cmd,
	output throttle_t    throttle_hold,
	output logic         cmd_valid,
	output logic         busy
);

	typedef enum logic [1:0] {
		ST_WAITING,
		ST_STARTING,
		ST_ACTIVE,
		ST_COMPLETE
	} ctrl_state_t;

	ctrl_state_t state;

	axis_rates_t setpoint_r;
	axis_rates_t gyro_r;
	throttle_t throttle_r;
	axis_rates_t pid_cmd;
	// yaw, roll, pitch
	logic [2:0] pid_done;
	logic [2:0] done_seen;
	logic pid_start;
	logic accept;
	logic all_done;

	// rate target plus angle error, clamped to 16 bits
	function automatic rate_t sat_add(input rate_t a, input rate_t b);
		logic signed [16:0] sum;
		rate_t result;
		sum = 17'(a) + 17'(b);
		if (sum > 17'sd32767) begin
			result = 16'sh7fff;
		end else if (sum < -17'sd32768) begin
			result = 16'sh8000;
		end else begin
			result = sum[15:0];
		end
		return result;
	endfunction

	assign busy = (state == ST_STARTING) || (state == ST_ACTIVE);
	assign accept = cycle_start && !busy;
	assign pid_start = (state == ST_STARTING);
	assign cmd_valid = (state == ST_COMPLETE);
	assign all_done = &(done_seen | pid_done);

	// one coherent sample set per control cycle
	always_ff @(posedge start_signal) begin
		if (accept) begin
			setpoint_r.yaw <= rate_targets.yaw;
			setpoint_r.roll <= sat_add(rate_targets.roll, angle_errors.roll);
			setpoint_r.pitch <= sat_add(rate_targets.pitch, angle_errors.pitch);
			gyro_r <= gyro_rates;
			throttle_r <= throttle;
		end
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= ST_WAITING;
			done_seen <= '0;
			axis_cmd <= '0;
			throttle_hold <= '0;
		end else begin
			case (state)
				ST_WAITING: begin
					if (accept) begin
						state <= ST_STARTING;
					end
				end
				ST_STARTING: begin
					done_seen <= '0;
					state <= ST_ACTIVE;
				end
				ST_ACTIVE: begin
					done_seen <= done_seen | pid_done;
					if (all_done) begin
						// publish, held until the next completion
						axis_cmd <= pid_cmd;
						throttle_hold <= throttle_r;
						state <= ST_COMPLETE;
					end
				end
				ST_COMPLETE: state <= accept ? ST_STARTING : ST_WAITING;
				default: state <= ST_WAITING;
			endcase
		end
	end

	rate_pid #(.GAINS(YAW_GAINS)) yaw_pid (
		.start_signal (start_signal),
		.resetn       (resetn),
		.pid_start    (pid_start),
		.setpoint     (setpoint_r.yaw),
		.gyro         (gyro_r.yaw),
		.pid_done     (pid_done[2]),
		.rate_cmd     (pid_cmd.yaw)
	);

	rate_pid #(.GAINS(ROLL_GAINS)) roll_pid (
		.start_signal (start_signal),
		.resetn       (resetn),
		.pid_start    (pid_start),
		.setpoint     (setpoint_r.roll),
		.gyro         (gyro_r.roll),
		.pid_done     (pid_done[1]),
		.rate_cmd     (pid_cmd.roll)
	);

	rate_pid #(.GAINS(PITCH_GAINS)) pitch_pid (
		.start_signal (start_signal),
		.resetn       (resetn),
		.pid_start    (pid_start),
		.setpoint     (setpoint_r.pitch),
		.gyro         (gyro_r.pitch),
		.pid_done     (pid_done[0]),
		.rate_cmd     (pid_cmd.pitch)
	);

endmodule

//--- rtl/flight_types_pkg.sv
package flight_types_pkg;

	// signed 12.4 deg/s
	// raw gyro words in 0.01 deg/s share the same container
	typedef logic signed [15:0] rate_t;

	// one rate per body axis
	typedef struct packed {
		rate_t yaw;
		rate_t roll;
		rate_t pitch;
	} axis_rates_t;

	// outer angle loop errors, yaw has none
	typedef struct packed {
		rate_t roll;
		rate_t pitch;
	} tilt_errors_t;

	// collective throttle, unsigned
	typedef logic [11:0] throttle_t;

	// one ESC command word
	typedef logic [11:0] motor_word_t;

	// X-frame motor set
	typedef struct packed {
		motor_word_t front_left;
		motor_word_t front_right;
		motor_word_t rear_left;
		motor_word_t rear_right;
	} motor_cmd_t;

	// full scale of a motor word
	localparam motor_word_t MOTOR_MAX = 12'd4095;

endpackage

//--- rtl/motor_mixer.sv
`timescale 1ns/1ps

module motor_mixer
	import flight_types_pkg::*;
(
	input  logic        start_signal,
	input  logic        resetn,
	input  logic        cmd_valid,
	input  axis_rates_t axis_cmd,
	input  throttle_t   throttle_hold,
	output motor_cmd_t  motor_cmd,
	output logic        motor_valid
);

	// 15 bits hold throttle plus three full-range axis terms
	logic signed [14:0] thr;
	logic signed [14:0] yaw_i;
	logic signed [14:0] roll_i;
	logic signed [14:0] pitch_i;
	logic signed [14:0] fl_sum;
	logic signed [14:0] fr_sum;
	logic signed [14:0] rl_sum;
	logic signed [14:0] rr_sum;
	motor_cmd_t mixed;

	function automatic motor_word_t clamp_motor(input logic signed [14:0] sum);
		motor_word_t word;
		if (sum < 15'sd0) begin
			word = '0;
		end else if (sum > $signed({3'b000, MOTOR_MAX})) begin
			word = MOTOR_MAX;
		end else begin
			word = sum[11:0];
		end
		return word;
	endfunction

	always_comb begin
		thr = {3'b000, throttle_hold};
		// integer part of 12.4, same as an arithmetic shift by 4
		yaw_i = 15'($signed(axis_cmd.yaw[15:4]));
		roll_i = 15'($signed(axis_cmd.roll[15:4]));
		pitch_i = 15'($signed(axis_cmd.pitch[15:4]));

		// X frame, diagonal pairs spin the same way
		fl_sum = thr + pitch_i + roll_i - yaw_i;
		fr_sum = thr + pitch_i - roll_i + yaw_i;
		rl_sum = thr - pitch_i + roll_i + yaw_i;
		rr_sum = thr - pitch_i - roll_i - yaw_i;

		mixed.front_left = clamp_motor(fl_sum);
		mixed.front_right = clamp_motor(fr_sum);
		mixed.rear_left = clamp_motor(rl_sum);
		mixed.rear_right = clamp_motor(rr_sum);
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			motor_cmd <= '0;
			motor_valid <= 1'b0;
		end else begin
			motor_valid <= cmd_valid;
			if (cmd_valid) begin
				motor_cmd <= mixed;
			end
		end
	end

endmodule

//--- rtl/pid_cfg_pkg.sv
package pid_cfg_pkg;

	// setpoint minus measured rate, one bit wider than rate_t
	typedef logic signed [16:0] err_t;

	// integral accumulator
	typedef logic signed [23:0] integ_t;

	// per-axis gains, all unsigned
	typedef struct packed {
		logic [7:0] kp;
		logic [7:0] ki;
		logic [7:0] kd;
	} gains_t;

	// symmetric clamp of the integral
	localparam integ_t INTEG_LIMIT = 24'sd8388607;

	// 0.01 deg/s to 12.4 format
	// 16 / 100 is close to 41 / 256
	localparam int IMU_SCALE_MUL = 41;
	localparam int IMU_SCALE_SHIFT = 8;

	// integral product is scaled down before it joins the sum
	localparam int INTEG_SHIFT = 8;

	// final scaling of the P + I + D sum
	localparam int GAIN_SHIFT = 6;

endpackage

//--- rtl/rate_loop_top.sv
`timescale 1ns/1ps

module rate_loop_top
	import flight_types_pkg::*;
	import pid_cfg_pkg::*;
#(
	// yaw runs softer than the tilt axes
	parameter gains_t YAW_GAINS = '{kp: 8'd24, ki: 8'd2, kd: 8'd8},
	parameter gains_t ROLL_GAINS = '{kp: 8'd40, ki: 8'd6, kd: 8'd20},
	parameter gains_t PITCH_GAINS = '{kp: 8'd44, ki: 8'd6, kd: 8'd22}
) (
	input  logic         start_signal,
	input  logic         resetn,
	input  logic         cycle_start,
	input  axis_rates_t  rate_targets,
	input  axis_rates_t  gyro_rates,
	input  tilt_errors_t angle_errors,
	input  throttle_t    throttle,
	output axis_rates_t  axis_cmd,
	output logic         cmd_valid,
	output motor_cmd_t   motor_cmd,
	output logic         motor_valid,
	output logic         busy
);

	throttle_t throttle_hold;

	body_frame_controller #(
		.YAW_GAINS   (YAW_GAINS),
		.ROLL_GAINS  (ROLL_GAINS),
		.PITCH_GAINS (PITCH_GAINS)
	) u_controller (
		.start_signal  (start_signal),
		.resetn        (resetn),
		.cycle_start   (cycle_start),
		.rate_targets  (rate_targets),
		.gyro_rates    (gyro_rates),
		.angle_errors  (angle_errors),
		.throttle      (throttle),
		.axis_cmd      (axis_cmd),
		.throttle_hold (throttle_hold),
		.cmd_valid     (cmd_valid),
		.busy          (busy)
	);

	motor_mixer u_mixer (
		.start_signal  (start_signal),
		.resetn        (resetn),
		.cmd_valid     (cmd_valid),
		.axis_cmd      (axis_cmd),
		.throttle_hold (throttle_hold),
		.motor_cmd     (motor_cmd),
		.motor_valid   (motor_valid)
	);

endmodule

//--- rtl/rate_pid.sv
`timescale 1ns/1ps

module rate_pid
	import flight_types_pkg::*;
	import pid_cfg_pkg::*;
#(
	parameter gains_t GAINS = '{kp: 8'd16, ki: 8'd0, kd: 8'd0}
) (
	input  logic  start_signal,
	input  logic  resetn,
	input  logic  pid_start,
	input  rate_t setpoint,
	input  rate_t gyro,
	output logic  pid_done,
	output rate_t rate_cmd
);

	// P product is taken in idle on pid_start
	typedef enum logic [1:0] {
		S_IDLE,
		S_INTEG,
		S_DERIV,
		S_SUM
	} pid_state_t;

	pid_state_t state;

	logic signed [31:0] gyro_scaled;
	rate_t measured;
	err_t err_now;

	err_t err_r;
	err_t prev_err;
	integ_t integ;
	integ_t integ_next;
	logic signed [24:0] integ_sum;
	logic signed [17:0] err_delta;

	logic signed [8:0] mul_gain;
	logic signed [24:0] mul_opd;
	logic signed [33:0] product;
	logic signed [31:0] acc;
	logic signed [31:0] acc_shifted;
	rate_t cmd_sat;

	// gyro rescale and error, valid while pid_start is high
	always_comb begin
		gyro_scaled = gyro * IMU_SCALE_MUL;
		// slice is the arithmetic shift, result fits in 16 bits
		measured = gyro_scaled[IMU_SCALE_SHIFT +: 16];
		err_now = err_t'(setpoint) - err_t'(measured);
	end

	// integral update, saturated
	always_comb begin
		integ_sum = 25'(integ) + 25'(err_r);
		if (integ_sum > 25'(INTEG_LIMIT)) begin
			integ_next = INTEG_LIMIT;
		end else if (integ_sum < -25'(INTEG_LIMIT)) begin
			integ_next = -INTEG_LIMIT;
		end else begin
			integ_next = integ_sum[23:0];
		end
		err_delta = 18'(err_r) - 18'(prev_err);
	end

	// one multiplier, operands picked by step
	always_comb begin
		case (state)
			S_INTEG: begin
				mul_gain = {1'b0, GAINS.ki};
				mul_opd = 25'(integ_next);
			end
			S_DERIV: begin
				mul_gain = {1'b0, GAINS.kd};
				mul_opd = 25'(err_delta);
			end
			default: begin
				mul_gain = {1'b0, GAINS.kp};
				mul_opd = 25'(err_now);
			end
		endcase
		product = mul_gain * mul_opd;
	end

	// final scale and clamp to 16 bits
	always_comb begin
		acc_shifted = acc >>> GAIN_SHIFT;
		if (acc_shifted > 32'sd32767) begin
			cmd_sat = 16'sh7fff;
		end else if (acc_shifted < -32'sd32768) begin
			cmd_sat = 16'sh8000;
		end else begin
			cmd_sat = acc_shifted[15:0];
		end
	end

	// working error and accumulator
	always_ff @(posedge start_signal) begin
		case (state)
			S_IDLE: begin
				if (pid_start) begin
					err_r <= err_now;
					acc <= 32'(product);
				end
			end
			S_INTEG: acc <= acc + 32'(product >>> INTEG_SHIFT);
			S_DERIV: acc <= acc + 32'(product);
			default: acc <= acc;
		endcase
	end

	// step sequencing and persistent loop state
	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
			pid_done <= 1'b0;
			rate_cmd <= '0;
			integ <= '0;
			prev_err <= '0;
		end else begin
			pid_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (pid_start) begin
						state <= S_INTEG;
					end
				end
				S_INTEG: state <= S_DERIV;
				S_DERIV: state <= S_SUM;
				S_SUM: begin
					rate_cmd <= cmd_sat;
					pid_done <= 1'b1;
					// memory for the next control cycle
					integ <= integ_next;
					prev_err <= err_r;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule
